// ==== source/port_mux_settings.svh ====
// --------------------
// port mux settings
// bus widths and write-route queue depth for the memory port mux
// --------------------

`ifndef PORT_MUX_SETTINGS_SVH
`define PORT_MUX_SETTINGS_SVH

`define ADDR_WIDTH    32  // byte address
`define DATA_WIDTH    32  // one beat
`define ID_WIDTH      4   // transaction id, encodes the requester
`define LEN_WIDTH     4   // burst has len + 1 beats
`define W_ROUTE_DEPTH 4   // outstanding write owners

`endif

// ==== source/mem_bus_pkg.sv ====
// --------------------
// memory bus types
// payload structs of the address, write, read and write-response channels
// --------------------

`include "port_mux_settings.svh"

package mem_bus_pkg;

  localparam int unsigned STRB_WIDTH = `DATA_WIDTH / 8;  // one strobe per byte

  typedef logic [`ID_WIDTH-1:0]   id_t;
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`LEN_WIDTH-1:0]  len_t;
  typedef logic [STRB_WIDTH-1:0]  strb_t;

  // --------------------
  // request side
  // --------------------

  // shared by ar and aw
  typedef struct packed {
    id_t   id;    // requester class lives in here
    addr_t addr;  // burst start
    len_t  len;   // beats minus one
  } addr_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;  // byte enables
    logic  last;  // final beat of the burst
  } w_chan_t;

  // --------------------
  // response side
  // --------------------

  typedef struct packed {
    id_t   id;    // routes the beat back
    data_t data;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;  // 00 is okay
  } b_chan_t;

endpackage

// ==== source/port_map_pkg.sv ====
// --------------------
// port map
// requester encoding, arbiter states and id classification rules
// --------------------

`include "port_mux_settings.svh"

package port_map_pkg;

  localparam int unsigned NUM_REQ = 3;  // icache, bypass, dcache

  // steers every mux and demux in the port mux
  typedef enum logic [1:0] {
    REQ_ICACHE = 2'd0,
    REQ_BYPASS = 2'd1,
    REQ_DCACHE = 2'd2
  } requester_e;

  typedef enum logic {
    ARB_IDLE   = 1'b0,  // free to pick a new input
    ARB_LOCKED = 1'b1   // output waiting, grant frozen
  } arb_state_e;

  localparam logic [`ID_WIDTH-1:0] DCACHE_ID = `ID_WIDTH'('b0111);
  localparam logic [`ID_WIDTH-1:0] ICACHE_ID = '0;

  // aw side, icache never writes so it is the fallback
  function automatic requester_e id_to_write_owner(input logic [`ID_WIDTH-1:0] id);
    if (id == DCACHE_ID)    return REQ_DCACHE;
    if (id[`ID_WIDTH-1])    return REQ_BYPASS;  // top bit marks bypass
    return REQ_ICACHE;
  endfunction

  // r and b side, anything unknown goes to the dcache
  function automatic requester_e id_to_resp_target(input logic [`ID_WIDTH-1:0] id);
    if (id == ICACHE_ID)    return REQ_ICACHE;
    if (id[`ID_WIDTH-1])    return REQ_BYPASS;
    return REQ_DCACHE;
  endfunction

  // round-robin successor
  function automatic requester_e next_requester(input requester_e r);
    case (r)
      REQ_ICACHE: return REQ_BYPASS;
      REQ_BYPASS: return REQ_DCACHE;
      default:    return REQ_ICACHE;
    endcase
  endfunction

endpackage

// ==== source/addr_arbiter.sv ====
// --------------------
// address arbiter
// round-robin pick of three address streams onto one output,
// grant locked while the output waits for ready
// --------------------

`timescale 1ns/1ns

module addr_arbiter
  import mem_bus_pkg::*;
  import port_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  // requester side
  input  addr_chan_t inp_chan_i  [3],
  input  logic       inp_valid_i [3],
  output logic       inp_ready_o [3],
  // shared side
  output addr_chan_t oup_chan_o,
  output logic       oup_valid_o,
  input  logic       oup_ready_i
);

  arb_state_e state_q;
  requester_e ptr_q;     // first input to look at
  requester_e lock_q;    // frozen grant
  requester_e cand;
  requester_e rr_grant;
  requester_e grant;
  logic       any_valid;
  logic       xfer;

  // --------------------
  // round-robin pick
  // --------------------
  always_comb begin
    rr_grant  = ptr_q;  // nothing valid, point at ptr
    any_valid = 1'b0;
    cand      = ptr_q;
    for (int k = 0; k < NUM_REQ; k++) begin
      cand = requester_e'(2'((int'(ptr_q) + k) % NUM_REQ));
      if (!any_valid && inp_valid_i[cand]) begin
        rr_grant  = cand;  // first valid at or after ptr
        any_valid = 1'b1;
      end
    end
  end

  assign grant = (state_q == ARB_LOCKED) ? lock_q : rr_grant;

  // output path is pure comb, zero latency
  assign oup_chan_o  = inp_chan_i[grant];
  assign oup_valid_o = (state_q == ARB_LOCKED) ? inp_valid_i[lock_q] : any_valid;
  assign xfer        = oup_valid_o & oup_ready_i;

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      inp_ready_o[i] = oup_ready_i && oup_valid_o && (int'(grant) == i);  // grant only
    end
  end

  // --------------------
  // lock and pointer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      ptr_q   <= REQ_ICACHE;
      lock_q  <= REQ_ICACHE;
    end else if (xfer) begin
      state_q <= ARB_IDLE;
      ptr_q   <= next_requester(grant);  // winner goes to the back
    end else if (oup_valid_o && state_q == ARB_IDLE) begin
      state_q <= ARB_LOCKED;  // stalled, hold this grant
      lock_q  <= grant;
    end
  end

  // stalled beat must not change under the memory
  a_hold_payload: assert property (@(posedge clk_i) disable iff (reset_i)
    (oup_valid_o && !oup_ready_i) |=> (oup_valid_o && $stable(oup_chan_o)));

endmodule

// ==== source/w_route_fifo.sv ====
// --------------------
// write route queue
// remembers the owner of each accepted write address so that write
// data is taken from that owner, with fall-through when empty
// --------------------

`timescale 1ns/1ns

`include "port_mux_settings.svh"

module w_route_fifo
  import mem_bus_pkg::*;
  import port_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  // shared aw stream
  input  addr_chan_t aw_chan_i,
  input  logic       aw_valid_i,   // from arbiter
  output logic       aw_valid_o,   // toward memory, held off while full
  input  logic       aw_ready_i,   // from memory
  output logic       aw_ready_o,   // toward arbiter
  // shared w stream at memory
  input  logic       w_valid_i,
  input  logic       w_last_i,
  input  logic       w_ready_i,
  // current write owner
  output requester_e write_owner_o,
  output logic       owner_valid_o
);

  localparam int unsigned DEPTH = `W_ROUTE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  requester_e       owner_q [DEPTH];  // owner storage
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  requester_e       aw_owner;
  logic             full, empty;
  logic             push, pop;
  logic             store, deq;

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  // full queue stalls aw on both sides of the handshake
  assign aw_valid_o = aw_valid_i & ~full;
  assign aw_ready_o = aw_ready_i & ~full;

  assign aw_owner = id_to_write_owner(aw_chan_i.id);
  assign push     = aw_valid_o & aw_ready_i;          // aw transfer
  assign pop      = w_valid_i & w_ready_i & w_last_i;  // burst done

  // empty queue with push and pop together: owner is used up on the spot
  assign store = push & ~(empty & pop);
  assign deq   = pop & ~empty;

  // --------------------
  // owner select
  // --------------------
  assign write_owner_o = !empty ? owner_q[rd_ptr_q] :
                         push   ? aw_owner : REQ_ICACHE;  // icache is the idle default
  assign owner_valid_o = ~empty | push;

  always_ff @(posedge clk_i) begin
    if (store) owner_q[wr_ptr_q] <= aw_owner;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (store) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (deq)   rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (store && !deq)      count_q <= count_q + 1'b1;
      else if (deq && !store) count_q <= count_q - 1'b1;
    end
  end

  // a new owner never lands on the unread head
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    store |-> (empty || wr_ptr_q != rd_ptr_q));

  // last beat at memory needs an owner, queued or falling through
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop |-> (!empty || push));

endmodule

// ==== source/resp_router.sv ====
// --------------------
// response router
// steers write data from the current owner, routes read beats and
// write responses back to the requester named by their id
// --------------------

`timescale 1ns/1ns

module resp_router
  import mem_bus_pkg::*;
  import port_map_pkg::*;
(
  input  logic       clk_i,    // assertions only
  input  logic       reset_i,  // assertions only
  // write owner from the route queue
  input  requester_e write_owner_i,
  input  logic       owner_valid_i,
  // w, requesters to memory
  input  w_chan_t    req_w_i       [3],
  input  logic       req_w_valid_i [3],
  output logic       req_w_ready_o [3],
  output w_chan_t    mem_w_o,
  output logic       mem_w_valid_o,
  input  logic       mem_w_ready_i,
  // r, memory to requesters
  input  r_chan_t    mem_r_i,
  input  logic       mem_r_valid_i,
  output logic       mem_r_ready_o,
  output r_chan_t    req_r_o       [3],
  output logic       req_r_valid_o [3],
  input  logic       req_r_ready_i [3],
  // b, memory to requesters
  input  b_chan_t    mem_b_i,
  input  logic       mem_b_valid_i,
  output logic       mem_b_ready_o,
  output b_chan_t    req_b_o       [3],
  output logic       req_b_valid_o [3],
  input  logic       req_b_ready_i [3]
);

  requester_e r_target;
  requester_e b_target;

  // --------------------
  // write data mux
  // --------------------
  assign mem_w_o       = req_w_i[write_owner_i];
  assign mem_w_valid_o = owner_valid_i & req_w_valid_i[write_owner_i];

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      req_w_ready_o[i] = owner_valid_i && mem_w_ready_i && (int'(write_owner_i) == i);
    end
  end

  // --------------------
  // r and b demux
  // --------------------
  assign r_target = id_to_resp_target(mem_r_i.id);
  assign b_target = id_to_resp_target(mem_b_i.id);

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      req_r_o[i]       = mem_r_i;  // payload fans out, valid picks one
      req_r_valid_o[i] = mem_r_valid_i && (int'(r_target) == i);
      req_b_o[i]       = mem_b_i;
      req_b_valid_o[i] = mem_b_valid_i && (int'(b_target) == i);
    end
  end

  assign mem_r_ready_o = req_r_ready_i[r_target];  // back-pressure from target only
  assign mem_b_ready_o = req_b_ready_i[b_target];

  // stalled write beat keeps its owner and payload
  a_w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_w_valid_o && !mem_w_ready_i) |=> (mem_w_valid_o && $stable(mem_w_o)));

endmodule

// ==== source/port_mux_top.sv ====
// --------------------
// memory port mux
// three requesters onto one burst bus, ar and aw arbitrated,
// w steered by the route queue, r and b routed by id
// --------------------

`timescale 1ns/1ns

module port_mux_top
  import mem_bus_pkg::*;
  import port_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  // requester side, indexed by requester_e
  input  addr_chan_t req_ar_i       [3],
  input  logic       req_ar_valid_i [3],
  output logic       req_ar_ready_o [3],
  input  addr_chan_t req_aw_i       [3],
  input  logic       req_aw_valid_i [3],
  output logic       req_aw_ready_o [3],
  input  w_chan_t    req_w_i        [3],
  input  logic       req_w_valid_i  [3],
  output logic       req_w_ready_o  [3],
  output r_chan_t    req_r_o        [3],
  output logic       req_r_valid_o  [3],
  input  logic       req_r_ready_i  [3],
  output b_chan_t    req_b_o        [3],
  output logic       req_b_valid_o  [3],
  input  logic       req_b_ready_i  [3],
  // memory side
  output addr_chan_t mem_ar_o,
  output logic       mem_ar_valid_o,
  input  logic       mem_ar_ready_i,
  output addr_chan_t mem_aw_o,
  output logic       mem_aw_valid_o,
  input  logic       mem_aw_ready_i,
  output w_chan_t    mem_w_o,
  output logic       mem_w_valid_o,
  input  logic       mem_w_ready_i,
  input  r_chan_t    mem_r_i,
  input  logic       mem_r_valid_i,
  output logic       mem_r_ready_o,
  input  b_chan_t    mem_b_i,
  input  logic       mem_b_valid_i,
  output logic       mem_b_ready_o
);

  logic       aw_arb_valid;  // before the full gate
  logic       aw_arb_ready;  // after the full gate
  requester_e write_owner;
  logic       owner_valid;

  // --------------------
  // address channels
  // --------------------
  addr_arbiter ar_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inp_chan_i  (req_ar_i),
    .inp_valid_i (req_ar_valid_i),
    .inp_ready_o (req_ar_ready_o),
    .oup_chan_o  (mem_ar_o),
    .oup_valid_o (mem_ar_valid_o),
    .oup_ready_i (mem_ar_ready_i)  // ar never sees the queue
  );

  addr_arbiter aw_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inp_chan_i  (req_aw_i),
    .inp_valid_i (req_aw_valid_i),
    .inp_ready_o (req_aw_ready_o),
    .oup_chan_o  (mem_aw_o),
    .oup_valid_o (aw_arb_valid),
    .oup_ready_i (aw_arb_ready)
  );

  w_route_fifo w_route (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .aw_chan_i     (mem_aw_o),
    .aw_valid_i    (aw_arb_valid),
    .aw_valid_o    (mem_aw_valid_o),
    .aw_ready_i    (mem_aw_ready_i),
    .aw_ready_o    (aw_arb_ready),
    .w_valid_i     (mem_w_valid_o),  // watches the shared w stream
    .w_last_i      (mem_w_o.last),
    .w_ready_i     (mem_w_ready_i),
    .write_owner_o (write_owner),
    .owner_valid_o (owner_valid)
  );

  // --------------------
  // data and responses
  // --------------------
  resp_router router (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .write_owner_i (write_owner),
    .owner_valid_i (owner_valid),
    .req_w_i       (req_w_i),
    .req_w_valid_i (req_w_valid_i),
    .req_w_ready_o (req_w_ready_o),
    .mem_w_o       (mem_w_o),
    .mem_w_valid_o (mem_w_valid_o),
    .mem_w_ready_i (mem_w_ready_i),
    .mem_r_i       (mem_r_i),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_r_ready_o (mem_r_ready_o),
    .req_r_o       (req_r_o),
    .req_r_valid_o (req_r_valid_o),
    .req_r_ready_i (req_r_ready_i),
    .mem_b_i       (mem_b_i),
    .mem_b_valid_i (mem_b_valid_i),
    .mem_b_ready_o (mem_b_ready_o),
    .req_b_o       (req_b_o),
    .req_b_valid_o (req_b_valid_o),
    .req_b_ready_i (req_b_ready_i)
  );

endmodule

// ==== dv/tb_checks.svh ====
// --------------------
// testbench checks
// typed compare tasks, stop at the first error
// --------------------

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;

task automatic stop_run();
  $display("sim failed");
  $fatal(1, "stopping at first error");
endtask

// plain-words failure
task automatic check_true(input bit ok, input string what);
  if (!ok) begin
    error_count++;
    $display("[ERROR] time %0t: %s", $time, what);
    stop_run();
  end
endtask

task automatic compare_addr(input string name, input addr_chan_t act, input addr_chan_t exp);
  if (act !== exp) begin
    error_count++;
    $display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp, act);
    stop_run();
  end
endtask

task automatic compare_w(input string name, input w_chan_t act, input w_chan_t exp);
  if (act !== exp) begin
    error_count++;
    $display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp, act);
    stop_run();
  end
endtask

task automatic compare_r(input string name, input r_chan_t act, input r_chan_t exp);
  if (act !== exp) begin
    error_count++;
    $display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp, act);
    stop_run();
  end
endtask

task automatic compare_b(input string name, input b_chan_t act, input b_chan_t exp);
  if (act !== exp) begin
    error_count++;
    $display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp, act);
    stop_run();
  end
endtask

`endif

// ==== dv/tb_port_mux.sv ====
// --------------------
// port mux testbench
// three requester models and a memory model around the port mux
// --------------------

`timescale 1ns/1ns

module tb_port_mux
  import mem_bus_pkg::*;
  import port_map_pkg::*;
();

  localparam int NUM_ROWS   = 16;
  localparam int FULL_START = 100;  // queue-full phase
  localparam int W_RELEASE  = 160;  // write data held back until here

  typedef struct {
    int    req;    // 0 icache, 1 bypass, 2 dcache
    bit    wr;
    id_t   id;
    addr_t addr;
    len_t  len;
    int    start;  // cycle after reset
  } row_t;

  logic clk_i, reset_i;
  addr_chan_t req_ar_i [3];
  logic req_ar_valid_i [3], req_ar_ready_o [3];
  addr_chan_t req_aw_i [3];
  logic req_aw_valid_i [3], req_aw_ready_o [3];
  w_chan_t req_w_i [3];
  logic req_w_valid_i [3], req_w_ready_o [3];
  r_chan_t req_r_o [3];
  logic req_r_valid_o [3], req_r_ready_i [3];
  b_chan_t req_b_o [3];
  logic req_b_valid_o [3], req_b_ready_i [3];
  addr_chan_t mem_ar_o, mem_aw_o;
  logic mem_ar_valid_o, mem_ar_ready_i, mem_aw_valid_o, mem_aw_ready_i;
  w_chan_t mem_w_o;
  logic mem_w_valid_o, mem_w_ready_i;
  r_chan_t mem_r_i;
  logic mem_r_valid_i, mem_r_ready_o;
  b_chan_t mem_b_i;
  logic mem_b_valid_i, mem_b_ready_o;

  row_t       tbl [NUM_ROWS];
  integer     seed = 55043;
  int         cycle = 0;
  w_chan_t    w_drive [3][$];  // beats each requester still has to send
  w_chan_t    w_exp [3][$];    // same beats, until the aw is accepted
  w_chan_t    exp_w [$];       // beats in aw acceptance order
  r_chan_t    exp_r [3][$];
  id_t        exp_b [3][$];
  addr_chan_t ar_q [$];        // reads the memory still owes
  id_t        aw_id_q [$];     // writes waiting for their last beat
  id_t        b_q [$];
  int         r_beat = 0;
  bit         ar_locked = 0, aw_locked = 0;
  int         ar_ptr = 0, aw_ptr = 0, ar_lock = 0, aw_lock = 0;
  int         aw_win = 0, ar_win = 0;  // transfers in the queue-full phase

  `include "tb_checks.svh"

  port_mux_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= reset_i ? 0 : cycle + 1;

  // --------------------
  // reference rules
  // --------------------
  function automatic int resp_owner(input id_t id);
    if (id == '0) return 0;          // icache
    if (id[`ID_WIDTH-1]) return 1;   // bypass
    return 2;
  endfunction

  function automatic int owner_of_write(input id_t id);
    if (id == 4'b0111) return 2;     // dcache
    if (id[`ID_WIDTH-1]) return 1;   // bypass
    return 0;
  endfunction

  function automatic int ref_grant(input bit locked, input int ptr, input int lock,
                                   input logic [2:0] v);
    int idx;
    if (locked) return v[lock] ? lock : -1;
    for (int k = 0; k < 3; k++) begin
      idx = (ptr + k) % 3;
      if (v[idx]) return idx;
    end
    return -1;
  endfunction

  task automatic step_arb(input bit xfer, input int g, inout bit locked, inout int ptr,
                          inout int lock);
    if (xfer) begin
      locked = 0;
      ptr    = (g + 1) % 3;  // winner to the back
    end else if (g >= 0 && !locked) begin
      locked = 1;
      lock   = g;
    end
  endtask

  task automatic fill_table();
    tbl[0]  = '{0, 0, 4'h0, 32'h1000, 4'd3, 0};   // all three at once
    tbl[1]  = '{1, 0, 4'h8, 32'h2000, 4'd0, 0};
    tbl[2]  = '{2, 0, 4'h7, 32'h3000, 4'd1, 0};
    tbl[3]  = '{1, 1, 4'h9, 32'h2100, 4'd2, 5};
    tbl[4]  = '{2, 1, 4'h7, 32'h3100, 4'd3, 5};
    tbl[5]  = '{1, 0, 4'hA, 32'h2200, 4'd1, 20};
    tbl[6]  = '{2, 0, 4'h7, 32'h3200, 4'd2, 20};
    tbl[7]  = '{0, 0, 4'h0, 32'h1100, 4'd1, 20};
    tbl[8]  = '{2, 1, 4'h7, 32'h3300, 4'd0, 30};
    tbl[9]  = '{1, 1, 4'hC, 32'h2300, 4'd1, 30};
    tbl[10] = '{1, 1, 4'hB, 32'h4000, 4'd1, FULL_START};  // fills the queue
    tbl[11] = '{2, 1, 4'h7, 32'h5000, 4'd2, FULL_START};
    tbl[12] = '{1, 1, 4'hD, 32'h4100, 4'd0, FULL_START};
    tbl[13] = '{2, 1, 4'h7, 32'h5100, 4'd1, FULL_START};
    tbl[14] = '{1, 1, 4'hE, 32'h4200, 4'd3, FULL_START};  // must wait
    tbl[15] = '{0, 0, 4'h0, 32'h1200, 4'd2, FULL_START + 10};
  endtask

  // --------------------
  // requester models
  // --------------------
  task automatic run_requester(input int r);
    w_chan_t beat;
    for (int n = 0; n < NUM_ROWS; n++) begin
      if (tbl[n].req != r) continue;
      while (cycle < tbl[n].start) begin
        @(posedge clk_i);
        #1;
      end
      if (tbl[n].wr) begin
        for (int k = 0; k <= int'(tbl[n].len); k++) begin
          beat = '{data: data_t'($random(seed)), strb: '1, last: (k == int'(tbl[n].len))};
          w_drive[r].push_back(beat);
          w_exp[r].push_back(beat);
        end
        exp_b[r].push_back(tbl[n].id);
        req_aw_i[r] = '{id: tbl[n].id, addr: tbl[n].addr, len: tbl[n].len};
        req_aw_valid_i[r] = 1'b1;
        do @(negedge clk_i); while (req_aw_ready_o[r] !== 1'b1);
        @(posedge clk_i);
        #1;
        req_aw_valid_i[r] = 1'b0;
      end else begin
        for (int k = 0; k <= int'(tbl[n].len); k++) begin
          exp_r[r].push_back('{id: tbl[n].id, data: data_t'(tbl[n].addr + k),
                               last: (k == int'(tbl[n].len))});
        end
        req_ar_i[r] = '{id: tbl[n].id, addr: tbl[n].addr, len: tbl[n].len};
        req_ar_valid_i[r] = 1'b1;
        do @(negedge clk_i); while (req_ar_ready_o[r] !== 1'b1);
        @(posedge clk_i);
        #1;
        req_ar_valid_i[r] = 1'b0;
      end
    end
  endtask

  // w beats in order, new bursts held back during the queue-full phase
  task automatic drive_w(input int r);
    bit in_burst;
    in_burst = 0;
    forever begin
      if (w_drive[r].size() > 0 && (in_burst || cycle < FULL_START || cycle >= W_RELEASE)) begin
        req_w_i[r] = w_drive[r].pop_front();
        req_w_valid_i[r] = 1'b1;
        in_burst = !req_w_i[r].last;
        do @(negedge clk_i); while (req_w_ready_o[r] !== 1'b1);
        @(posedge clk_i);
        #1;
        req_w_valid_i[r] = 1'b0;
      end else begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  // --------------------
  // monitor and memory
  // --------------------
  initial begin
    int g_ar, g_aw, t, wo;
    bit ar_x, aw_x, win;
    w_chan_t beat;
    forever begin
      @(negedge clk_i);  // everything settled since the drive point
      if (!reset_i) begin
        win  = (cycle >= FULL_START && cycle < W_RELEASE);
        g_ar = ref_grant(ar_locked, ar_ptr, ar_lock,
                         {req_ar_valid_i[2], req_ar_valid_i[1], req_ar_valid_i[0]});
        g_aw = ref_grant(aw_locked, aw_ptr, aw_lock,
                         {req_aw_valid_i[2], req_aw_valid_i[1], req_aw_valid_i[0]});
        check_true(mem_ar_valid_o === (g_ar >= 0), "read address valid does not follow requests");
        if (g_ar >= 0) compare_addr("mem_ar_o", mem_ar_o, req_ar_i[g_ar]);
        // aw held off while the owner queue is full
        check_true(mem_aw_valid_o === (g_aw >= 0 && aw_id_q.size() < `W_ROUTE_DEPTH),
                   "write address valid does not follow requests and queue space");
        if (mem_aw_valid_o) compare_addr("mem_aw_o", mem_aw_o, req_aw_i[g_aw]);
        ar_x = mem_ar_valid_o && mem_ar_ready_i;
        aw_x = mem_aw_valid_o && mem_aw_ready_i;
        for (int k = 0; k < 3; k++) begin
          check_true(req_ar_ready_o[k] === (ar_x && k == g_ar), "read ready at wrong requester");
          check_true(req_aw_ready_o[k] === (aw_x && k == g_aw), "write ready at wrong requester");
        end
        if (ar_x) begin
          ar_q.push_back(mem_ar_o);
          if (win) ar_win++;
        end
        if (aw_x) begin  // owner's burst joins the expected w order
          aw_id_q.push_back(mem_aw_o.id);
          if (win) aw_win++;
          do begin
            beat = w_exp[g_aw].pop_front();
            exp_w.push_back(beat);
          end while (!beat.last);
        end
        step_arb(ar_x, g_ar, ar_locked, ar_ptr, ar_lock);
        step_arb(aw_x, g_aw, aw_locked, aw_ptr, aw_lock);
        // w owner is the oldest open write, or this cycle's aw when none is open
        wo = (aw_id_q.size() > 0) ? owner_of_write(aw_id_q[0]) : -1;
        check_true(mem_w_valid_o === ((wo >= 0) ? (req_w_valid_i[wo] === 1'b1) : 1'b0),
                   "write data valid does not follow the write owner");
        for (int k = 0; k < 3; k++)
          check_true(req_w_ready_o[k] === (mem_w_ready_i && k == wo),
                     "write data ready at wrong requester");
        if (mem_w_valid_o && mem_w_ready_i) begin
          check_true(exp_w.size() > 0, "write beat with no accepted write address");
          compare_w("mem_w_o", mem_w_o, exp_w.pop_front());
          if (mem_w_o.last) b_q.push_back(aw_id_q.pop_front());
        end
        if (mem_r_valid_i) begin
          t = resp_owner(mem_r_i.id);
          for (int k = 0; k < 3; k++)
            check_true(req_r_valid_o[k] === (k == t), "read beat routed to wrong requester");
          check_true(mem_r_ready_o === req_r_ready_i[t], "read ready not taken from the target");
          if (mem_r_ready_o) begin
            check_true(exp_r[t].size() > 0, "unexpected read beat");
            compare_r("req_r_o", req_r_o[t], exp_r[t].pop_front());
            r_beat = mem_r_i.last ? 0 : r_beat + 1;
            if (mem_r_i.last) void'(ar_q.pop_front());
          end
        end
        if (mem_b_valid_i) begin
          t = resp_owner(mem_b_i.id);
          for (int k = 0; k < 3; k++)
            check_true(req_b_valid_o[k] === (k == t), "write response to wrong requester");
          check_true(mem_b_ready_o === req_b_ready_i[t],
                     "write response ready not taken from the target");
          if (mem_b_ready_o) begin
            check_true(exp_b[t].size() > 0, "extra write response");
            compare_b("req_b_o", req_b_o[t], '{id: exp_b[t].pop_front(), resp: 2'b00});
            void'(b_q.pop_front());
          end
        end
      end
    end
  end

  // memory drive, random address and data readiness
  initial begin
    mem_ar_ready_i = 1'b0;
    mem_aw_ready_i = 1'b0;
    mem_w_ready_i  = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_b_valid_i  = 1'b0;
    mem_r_i        = '0;
    mem_b_i        = '0;
    forever begin
      @(posedge clk_i);
      #1;
      mem_ar_ready_i = ($random(seed) & 3) != 0;
      mem_aw_ready_i = ($random(seed) & 3) != 0;
      mem_w_ready_i  = ($random(seed) & 3) != 0;
      mem_r_valid_i  = ar_q.size() > 0;
      if (ar_q.size() > 0)
        mem_r_i = '{id: ar_q[0].id, data: data_t'(ar_q[0].addr + r_beat),
                    last: (r_beat == int'(ar_q[0].len))};
      mem_b_valid_i = b_q.size() > 0;
      if (b_q.size() > 0) mem_b_i = '{id: b_q[0], resp: 2'b00};
    end
  end

  // watchdog
  initial begin
    repeat (200 * NUM_ROWS) @(posedge clk_i);
    $display("timeout: traffic did not finish in %0d cycles", 200 * NUM_ROWS);
    stop_run();
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    reset_i = 1'b1;
    for (int i = 0; i < 3; i++) begin
      req_ar_i[i] = '0;
      req_ar_valid_i[i] = 1'b0;
      req_aw_i[i] = '0;
      req_aw_valid_i[i] = 1'b0;
      req_w_i[i] = '0;
      req_w_valid_i[i] = 1'b0;
      req_r_ready_i[i] = 1'b1;  // requesters always sink responses
      req_b_ready_i[i] = 1'b1;
    end
    fill_table();
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    fork
      drive_w(1);
      drive_w(2);
    join_none
    fork
      run_requester(0);
      run_requester(1);
      run_requester(2);
    join
    // drain all outstanding traffic
    while (ar_q.size() || b_q.size() || exp_w.size() || aw_id_q.size() || w_drive[1].size() ||
           w_drive[2].size() || exp_r[0].size() || exp_r[1].size() || exp_r[2].size() ||
           exp_b[1].size() || exp_b[2].size())
      @(negedge clk_i);
    check_true(aw_win == `W_ROUTE_DEPTH, "write addresses accepted past a full queue");
    check_true(ar_win >= 1, "read address blocked while the write queue was full");
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
+incdir+dv
source/mem_bus_pkg.sv
source/port_map_pkg.sv
source/addr_arbiter.sv
source/w_route_fifo.sv
source/resp_router.sv
source/port_mux_top.sv
dv/tb_port_mux.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the port mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_port_mux -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_port_mux > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator returned status $run_status"
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "no pass line in $LOG"
  exit 1
fi
exit 0
